//--- bench/merge_golden.txt
// Hex word digits: phase, channel, header flag, then the 16-bit body
// Phase f gives a channel's expected word count, phase e ends the list
// Phase 0, mixed traffic under a random stall
001a203 000c001 000c002
001a104 000c011
001a005
011b301 010d001 010d002 010d003
011b202 010d011 010d012
// Phase 1, both channels filled while stalled
101a211 100c101 100c102
101a112 100c111
101a313 100c121 100c122 100c123
111b121 110d101
111b222 110d111 110d112
111b123 110d121
// Phase 2, long stall that fills both FIFOs
201a531 200c201 200c202 200c203 200c204 200c205
201a532 200c211 200c212 200c213 200c214 200c215
201a533 200c221 200c222 200c223 200c224 200c225
201a534 200c231 200c232 200c233 200c234 200c235
211b631 210d201 210d202 210d203 210d204 210d205 210d206
211b632 210d211 210d212 210d213 210d214 210d215 210d216
211b633 210d221 210d222 210d223 210d224 210d225 210d226
// Expected words per channel
f000027 f100023
e000000

//--- vlog.f
design/xclk_pkg.sv
design/dc_ram.sv
design/dc_fifo_core.sv
design/fifo_dc_bram.sv
design/pkt_arbiter.sv
design/xclk_merge_top.sv
bench/xclk_merge_checker.sv
bench/tb_xclk_merge.sv

//--- bench/tb_xclk_merge.sv
module tb_xclk_merge;
    import xclk_pkg::*;

    logic        rd_clk;
    logic        wr_clk_a;
    logic        wr_clk_b;
    logic        reset_n;
    fifo_word_t  enq_data_a;
    fifo_word_t  enq_data_b;
    logic        enq_en_a;
    logic        enq_en_b;
    logic        not_full_a;
    logic        not_full_b;
    logic        almost_full_a;
    logic        almost_full_b;
    logic        out_stall;
    logic        out_valid;
    fifo_word_t  out_word;
    logic        out_src;

    // Golden entry digits from the top: phase, channel, header flag, 16-bit body
    logic [27:0] golden [0:127];
    fifo_word_t  exp_q [2][$];
    int          exp_cnt [2];
    int          got_cnt [2];
    int          phase_words [3];
    int          got_total;
    int          n_rec;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          cur_phase;
    int          pkt_left;
    logic        pkt_src;
    logic        fair_q [$];
    logic [31:0] rand_state;
    logic        seen_af [2];
    logic        seen_full [2];
    logic        load_done;
    int          watchdog_limit;

    xclk_merge_top i_xclk_merge_top (.*);

    initial
    begin
        rd_clk = 1'b0;
        forever #10 rd_clk = ~rd_clk;
    end

    initial
    begin
        wr_clk_a = 1'b0;
        forever #7 wr_clk_a = ~wr_clk_a;
    end

    initial
    begin
        wr_clk_b = 1'b0;
        forever #13 wr_clk_b = ~wr_clk_b;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Pushes every word of one channel and phase, one write per two clocks
    task automatic feed_channel(input int ch, input int ph);
        fifo_word_t w;
        for (int i = 0; i < n_rec; i++)
        begin
            if (golden[i][27:24] == ph && golden[i][23:20] == ch)
            begin
                w = golden[i][16:0];
                if (ch == 0)
                begin
                    // Full is read between edges where the write pointer has settled
                    @(negedge wr_clk_a);
                    while (!not_full_a) @(negedge wr_clk_a);
                    @(posedge wr_clk_a);
                    enq_en_a <= 1'b1;
                    enq_data_a <= w;
                    @(posedge wr_clk_a);
                    enq_en_a <= 1'b0;
                end
                else
                begin
                    @(negedge wr_clk_b);
                    while (!not_full_b) @(negedge wr_clk_b);
                    @(posedge wr_clk_b);
                    enq_en_b <= 1'b1;
                    enq_data_b <= w;
                    @(posedge wr_clk_b);
                    enq_en_b <= 1'b0;
                end
            end
        end
    endtask

    task automatic random_stall(input int cycles);
        repeat (cycles)
        begin
            @(posedge rd_clk);
            rand_state = lcg_next(rand_state);
            out_stall <= rand_state[31];
        end
        @(posedge rd_clk);
        out_stall <= 1'b0;
    endtask

    task automatic wait_drained(input int target);
        while (got_total < target) @(posedge rd_clk);
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before)
        begin
            $display("test %-14s ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %-14s FAILED with %0d errors", name, errors - err_before);
        end
    endtask

    // Compares one single-bit DUT output against the level it must have
    task automatic check_flag(input string name, input logic exp, input logic got);
        assert (got === exp)
        else
        begin
            $display("[FAIL] t=%0t %s exp=%b got=%b", $time, name, exp, got);
            errors++;
        end
    endtask

    // Scoreboard step for one output word, covering order, source and packet framing
    task automatic check_word(input logic src, input fifo_word_t w);
        fifo_word_t exp;
        int         ch;
        ch = src;
        got_cnt[ch]++;
        got_total++;
        assert (exp_q[ch].size() > 0)
        else
        begin
            $display("Channel %0d sent a word at t=%0t after its whole stream was out", ch, $time);
            errors++;
        end
        if (exp_q[ch].size() > 0)
        begin
            exp = exp_q[ch].pop_front();
            assert (w == exp)
            else
            begin
                $display("[FAIL] t=%0t out_word exp=%05h got=%05h", $time, exp, w);
                errors++;
            end
        end
        if (pkt_left == 0)
        begin
            assert (w[word_bits] == 1'b1)
            else
            begin
                $display("[FAIL] t=%0t out_word header flag exp=1 got=0", $time);
                errors++;
            end
            pkt_src = src;
            // Length is nibble 2 of a header body
            pkt_left = w[11:8];
            if (cur_phase == 1)
            begin
                fair_q.push_back(src);
            end
        end
        else
        begin
            assert (src == pkt_src)
            else
            begin
                $display("[FAIL] t=%0t out_src exp=%0d got=%0d", $time, pkt_src, src);
                errors++;
            end
            assert (w[word_bits] == 1'b0)
            else
            begin
                $display("[FAIL] t=%0t out_word header flag exp=0 got=1", $time);
                errors++;
            end
            pkt_left--;
        end
    endtask

    // Output is sampled mid-cycle, away from the rd_clk edge
    always @(negedge rd_clk)
    begin
        if (reset_n == 1'b0 && out_valid === 1'b1)
        begin
            check_word(out_src, out_word);
        end
    end

    // Full only counts once almost_full has already been seen
    always @(negedge wr_clk_a)
    begin
        if (cur_phase == 2 && almost_full_a)
            seen_af[0] = 1'b1;
        if (cur_phase == 2 && !not_full_a && seen_af[0])
            seen_full[0] = 1'b1;
    end

    always @(negedge wr_clk_b)
    begin
        if (cur_phase == 2 && almost_full_b)
            seen_af[1] = 1'b1;
        if (cur_phase == 2 && !not_full_b && seen_af[1])
            seen_full[1] = 1'b1;
    end

    initial
    begin
        wait (load_done == 1'b1);
        #(watchdog_limit);
        $display("Run timed out before all expected words came out of the DUT");
        $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        int e0;
        int target;
        int all_fails;
        reset_n = 1'b1;
        enq_en_a = 1'b0;
        enq_en_b = 1'b0;
        enq_data_a = '0;
        enq_data_b = '0;
        out_stall = 1'b0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        got_total = 0;
        got_cnt = '{0, 0};
        exp_cnt = '{0, 0};
        phase_words = '{0, 0, 0};
        seen_af = '{1'b0, 1'b0};
        seen_full = '{1'b0, 1'b0};
        cur_phase = -1;
        pkt_left = 0;
        pkt_src = 1'b0;
        load_done = 1'b0;
        rand_state = 32'he30d00c6;

        $readmemh("bench/merge_golden.txt", golden);
        n_rec = 0;
        // Phase e closes the list
        while (n_rec < 128 && golden[n_rec][27:24] != 4'he) n_rec++;
        for (int i = 0; i < n_rec; i++)
        begin
            if (golden[i][27:24] == 4'hf)
            begin
                exp_cnt[golden[i][20]] = golden[i][15:0];
            end
            else
            begin
                exp_q[golden[i][20]].push_back(golden[i][16:0]);
                phase_words[golden[i][25:24]]++;
            end
        end
        watchdog_limit = (phase_words[0] + phase_words[1] + phase_words[2]) * 40 * 20 + 5000;
        load_done = 1'b1;

        repeat (3) @(posedge rd_clk);
        reset_n <= 1'b0;

        e0 = errors;
        @(negedge rd_clk);
        check_flag("out_valid", 1'b0, out_valid);
        check_flag("not_full_a", 1'b1, not_full_a);
        check_flag("not_full_b", 1'b1, not_full_b);
        check_flag("almost_full_a", 1'b0, almost_full_a);
        check_flag("almost_full_b", 1'b0, almost_full_b);
        report_test("reset_state", e0);

        // Both producers run while the consumer stalls at random
        e0 = errors;
        cur_phase = 0;
        target = phase_words[0];
        fork
            feed_channel(0, 0);
            feed_channel(1, 0);
            random_stall(60);
        join
        wait_drained(target);
        report_test("mixed_traffic", e0);

        // Both FIFOs are filled behind a stall so every grant sees two headers
        e0 = errors;
        cur_phase = 1;
        target += phase_words[1];
        @(posedge rd_clk);
        out_stall <= 1'b1;
        fork
            feed_channel(0, 1);
            feed_channel(1, 1);
        join
        // Last write pointers need a few rd_clk cycles to cross over
        repeat (10) @(posedge rd_clk);
        out_stall <= 1'b0;
        wait_drained(target);
        for (int i = 1; i < fair_q.size(); i++)
        begin
            assert (fair_q[i] != fair_q[i - 1])
            else
            begin
                $display("[FAIL] t=%0t out_src of fair packet %0d exp=%0d got=%0d",
                         $time, i, !fair_q[i - 1], fair_q[i]);
                errors++;
            end
        end
        report_test("fairness", e0);

        // A long stall pushes both FIFOs past almost full into full
        e0 = errors;
        cur_phase = 2;
        target += phase_words[2];
        @(posedge rd_clk);
        out_stall <= 1'b1;
        fork
            feed_channel(0, 2);
            feed_channel(1, 2);
            begin
                repeat (80) @(posedge rd_clk);
                out_stall <= 1'b0;
            end
        join
        wait_drained(target);
        assert (seen_full[0] && seen_full[1])
        else
        begin
            $display("A FIFO never showed almost_full followed by full during the long stall");
            errors++;
        end
        report_test("back_pressure", e0);

        // Extra cycles let any duplicated word show up before counting
        e0 = errors;
        repeat (20) @(posedge rd_clk);
        for (int ch = 0; ch < 2; ch++)
        begin
            assert (got_cnt[ch] == exp_cnt[ch])
            else
            begin
                $display("[FAIL] t=%0t word count of out_src=%0d exp=%0d got=%0d",
                         $time, ch, exp_cnt[ch], got_cnt[ch]);
                errors++;
            end
        end
        report_test("completion", e0);

        all_fails = errors + i_xclk_merge_top.u_arbiter.u_arb_checker.fails;
        $display("tests=%0d failed=%0d words=%0d errors=%0d assertion_failures=%0d",
                 tests_run, tests_failed, got_total, errors,
                 i_xclk_merge_top.u_arbiter.u_arb_checker.fails);
        if (all_fails == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- bench/xclk_merge_checker.sv
module xclk_merge_checker (
    input logic rd_clk,
    input logic reset_n,
    input logic deq_a,
    input logic deq_b,
    input logic not_empty_a,
    input logic not_empty_b,
    input logic out_stall,
    input logic out_valid
);
    // Failed assertions, read by the testbench for its closing verdict
    int fails = 0;

    // A dequeue may only take a word that the front actually holds
    a_deq_a: assert property (@(posedge rd_clk) disable iff (reset_n) deq_a |-> not_empty_a)
    else
    begin
        $error("deq_a pulsed while the channel a front was empty");
        fails++;
    end

    a_deq_b: assert property (@(posedge rd_clk) disable iff (reset_n) deq_b |-> not_empty_b)
    else
    begin
        $error("deq_b pulsed while the channel b front was empty");
        fails++;
    end

    // Only one channel feeds the output in any cycle
    a_one_deq: assert property (@(posedge rd_clk) disable iff (reset_n) !(deq_a && deq_b))
    else
    begin
        $error("deq_a and deq_b were high in the same cycle");
        fails++;
    end

    // A stalled cycle takes no word, so nothing can come out one cycle later
    a_stall: assert property (@(posedge rd_clk) disable iff (reset_n) out_stall |=> !out_valid)
    else
    begin
        $error("out_valid rose right after a cycle with out_stall high");
        fails++;
    end

endmodule

bind pkt_arbiter xclk_merge_checker u_arb_checker (.*);

//--- design/xclk_merge_top.sv
module xclk_merge_top (
    input  logic                 reset_n,
    input  logic                 rd_clk,

    input  logic                 wr_clk_a,
    input  xclk_pkg::fifo_word_t enq_data_a,
    input  logic                 enq_en_a,
    output logic                 not_full_a,
    output logic                 almost_full_a,

    input  logic                 wr_clk_b,
    input  xclk_pkg::fifo_word_t enq_data_b,
    input  logic                 enq_en_b,
    output logic                 not_full_b,
    output logic                 almost_full_b,

    input  logic                 out_stall,
    output logic                 out_valid,
    output xclk_pkg::fifo_word_t out_word,
    output logic                 out_src
);
    import xclk_pkg::*;

    // Front words and handshakes between the FIFOs and the arbiter
    fifo_word_t first_a;
    fifo_word_t first_b;
    logic       not_empty_a;
    logic       not_empty_b;
    logic       deq_a;
    logic       deq_b;

    fifo_dc_bram fifo_a (
        .reset_n     (reset_n),
        .wr_clk      (wr_clk_a),
        .enq_data    (enq_data_a),
        .enq_en      (enq_en_a),
        .not_full    (not_full_a),
        .almost_full (almost_full_a),
        .rd_clk      (rd_clk),
        .first       (first_a),
        .deq_en      (deq_a),
        .not_empty   (not_empty_a)
    );

    fifo_dc_bram fifo_b (
        .reset_n     (reset_n),
        .wr_clk      (wr_clk_b),
        .enq_data    (enq_data_b),
        .enq_en      (enq_en_b),
        .not_full    (not_full_b),
        .almost_full (almost_full_b),
        .rd_clk      (rd_clk),
        .first       (first_b),
        .deq_en      (deq_b),
        .not_empty   (not_empty_b)
    );

    // Merges both channels onto one stream, one packet at a time
    pkt_arbiter u_arbiter (
        .reset_n     (reset_n),
        .rd_clk      (rd_clk),
        .first_a     (first_a),
        .not_empty_a (not_empty_a),
        .deq_a       (deq_a),
        .first_b     (first_b),
        .not_empty_b (not_empty_b),
        .deq_b       (deq_b),
        .out_stall   (out_stall),
        .out_valid   (out_valid),
        .out_word    (out_word),
        .out_src     (out_src)
    );

endmodule

//--- design/pkt_arbiter.sv
module pkt_arbiter (
    input  logic                 reset_n,
    input  logic                 rd_clk,

    input  xclk_pkg::fifo_word_t first_a,
    input  logic                 not_empty_a,
    output logic                 deq_a,

    input  xclk_pkg::fifo_word_t first_b,
    input  logic                 not_empty_b,
    output logic                 deq_b,

    input  logic                 out_stall,
    output logic                 out_valid,
    output xclk_pkg::fifo_word_t out_word,
    output logic                 out_src
);
    import xclk_pkg::*;

    fifo_body_u          body_a;
    fifo_body_u          body_b;
    logic                hdr_a;
    logic                hdr_b;
    logic                pick_ok;
    logic                pick_b;
    logic [len_bits-1:0] pick_len;
    logic                take;

    // Packet state
    logic                busy;
    logic                gnt_b;
    logic                last_b;
    logic [len_bits-1:0] remaining;

    assign body_a = first_a[word_bits-1:0];
    assign body_b = first_b[word_bits-1:0];

    // A channel competes only while its front word is a header
    assign hdr_a = not_empty_a && first_a[word_bits];
    assign hdr_b = not_empty_b && first_b[word_bits];
    assign pick_ok = hdr_a || hdr_b;

    // With both ready the channel not served last wins
    assign pick_b = hdr_b && (!hdr_a || !last_b);
    assign pick_len = pick_b ? body_b.hdr[hdr_len_nib] : body_a.hdr[hdr_len_nib];

    always_comb
    begin
        deq_a = 1'b0;
        deq_b = 1'b0;
        if (!out_stall)
        begin
            if (busy)
            begin
                // Payload words drain from the granted channel only
                deq_a = !gnt_b && not_empty_a;
                deq_b = gnt_b && not_empty_b;
            end
            else if (pick_ok)
            begin
                // Header leaves in the same cycle the grant is made
                deq_a = !pick_b;
                deq_b = pick_b;
            end
        end
    end

    assign take = deq_a || deq_b;

    always_ff @(posedge rd_clk)
    begin
        if (reset_n)
        begin
            busy <= 1'b0;
            gnt_b <= 1'b0;
            // Channel a goes first after reset
            last_b <= 1'b1;
            remaining <= '0;
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= take;
            if (!busy && take)
            begin
                gnt_b <= pick_b;
                last_b <= pick_b;
                remaining <= pick_len;
                // A header with no payload finishes at once
                busy <= pick_len != '0;
            end
            else if (busy && take)
            begin
                remaining <= remaining - 1'b1;
                if (remaining == len_bits'(1))
                begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Output word follows its dequeue by exactly one cycle
    always_ff @(posedge rd_clk)
    begin
        if (take)
        begin
            out_word <= deq_b ? first_b : first_a;
            out_src <= deq_b;
        end
    end

endmodule

//--- design/fifo_dc_bram.sv
module fifo_dc_bram (
    input  logic                 reset_n,

    input  logic                 wr_clk,
    input  xclk_pkg::fifo_word_t enq_data,
    input  logic                 enq_en,
    output logic                 not_full,
    output logic                 almost_full,

    input  logic                 rd_clk,
    output xclk_pkg::fifo_word_t first,
    input  logic                 deq_en,
    output logic                 not_empty
);
    logic core_full;
    logic core_empty;
    logic core_rd;

    assign not_full = !core_full;

    // Refill the front whenever it is vacant or being consumed this cycle
    assign core_rd = (!not_empty || deq_en) && !core_empty;

    always_ff @(posedge rd_clk)
    begin
        if (reset_n)
        begin
            not_empty <= 1'b0;
        end
        else
        begin
            // Front stays valid when untouched, or becomes valid when the core
            // hands over a word
            not_empty <= (not_empty && !deq_en) || !core_empty;
        end
    end

    // The core read data is the front word itself
    dc_fifo_core u_core (
        .reset_n        (reset_n),
        .wr_clk         (wr_clk),
        .wr_data        (enq_data),
        .wr_req         (enq_en),
        .wr_full        (core_full),
        .wr_almost_full (almost_full),
        .rd_clk         (rd_clk),
        .rd_req         (core_rd),
        .rd_data        (first),
        .rd_empty       (core_empty)
    );

endmodule

//--- design/dc_fifo_core.sv
module dc_fifo_core (
    input  logic                 reset_n,

    input  logic                 wr_clk,
    input  xclk_pkg::fifo_word_t wr_data,
    input  logic                 wr_req,
    output logic                 wr_full,
    output logic                 wr_almost_full,

    input  logic                 rd_clk,
    input  logic                 rd_req,
    output xclk_pkg::fifo_word_t rd_data,
    output logic                 rd_empty
);
    import xclk_pkg::*;

    // Write domain pointers and the read pointer as seen from there
    logic [addr_bits:0]   wr_bin;
    logic [addr_bits:0]   wr_bin_next;
    logic [addr_bits:0]   wr_gray;
    logic [addr_bits:0]   rd_gray_s1;
    logic [addr_bits:0]   rd_gray_s2;
    logic [addr_bits:0]   rd_bin_w;
    logic [addr_bits:0]   used_w;
    logic                 wr_ok;

    // Read domain pointers and the write pointer as seen from there
    logic [addr_bits:0]   rd_bin;
    logic [addr_bits:0]   rd_bin_next;
    logic [addr_bits:0]   rd_gray;
    logic [addr_bits:0]   wr_gray_s1;
    logic [addr_bits:0]   wr_gray_s2;
    logic                 rd_ok;
    logic [addr_bits-1:0] rd_addr;

    // A write request against a full FIFO is dropped here
    assign wr_ok = wr_req && !wr_full;
    assign wr_bin_next = wr_bin + wr_ok;

    always_ff @(posedge wr_clk)
    begin
        if (reset_n)
        begin
            wr_bin <= '0;
            wr_gray <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end
        else
        begin
            wr_bin <= wr_bin_next;
            wr_gray <= bin2gray(wr_bin_next);
            // Two flops bring the read Gray pointer into wr_clk
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
        end
    end

    // Occupancy is pessimistic since the read pointer arrives late
    assign rd_bin_w = gray2bin(rd_gray_s2);
    assign used_w = wr_bin - rd_bin_w;

    // Full leaves the slot behind the read pointer untouched
    assign wr_full = used_w >= (addr_bits + 1)'(usable_entries);
    assign wr_almost_full = used_w >= (addr_bits + 1)'(af_level);

    // Empty compares Gray codes directly, no conversion needed
    assign rd_empty = rd_gray == wr_gray_s2;
    assign rd_ok = rd_req && !rd_empty;
    assign rd_bin_next = rd_bin + rd_ok;

    // Without a read the RAM re-reads the last word taken, so rd_data holds
    // still until the next accepted request
    assign rd_addr = rd_ok ? rd_bin[addr_bits-1:0] : rd_bin[addr_bits-1:0] - 1'b1;

    always_ff @(posedge rd_clk)
    begin
        if (reset_n)
        begin
            rd_bin <= '0;
            rd_gray <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end
        else
        begin
            rd_bin <= rd_bin_next;
            rd_gray <= bin2gray(rd_bin_next);
            // Two flops bring the write Gray pointer into rd_clk
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
        end
    end

    dc_ram u_ram (
        .wr_clk  (wr_clk),
        .wr_en   (wr_ok),
        .wr_addr (wr_bin[addr_bits-1:0]),
        .wr_data (wr_data),
        .rd_clk  (rd_clk),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

//--- design/dc_ram.sv
module dc_ram (
    input  logic                           wr_clk,
    input  logic                           wr_en,
    input  logic [xclk_pkg::addr_bits-1:0] wr_addr,
    input  xclk_pkg::fifo_word_t           wr_data,

    input  logic                           rd_clk,
    input  logic [xclk_pkg::addr_bits-1:0] rd_addr,
    output xclk_pkg::fifo_word_t           rd_data
);
    import xclk_pkg::*;

    // Plain array so synthesis can map it onto a block RAM
    fifo_word_t mem [fifo_entries];

    // Write port lives entirely in the producer clock domain
    always_ff @(posedge wr_clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read on the consumer clock
    // The word for an address shows up one rd_clk cycle after it is presented
    always_ff @(posedge rd_clk)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- design/xclk_pkg.sv
package xclk_pkg;

    // Payload width of one FIFO word, the header flag sits in the bit above it
    localparam int word_bits = 16;

    // Storage entries in each dual-clock RAM
    localparam int fifo_entries = 16;
    localparam int addr_bits = $clog2(fifo_entries);

    // Producers are warned once this many slots or fewer remain free
    localparam int af_threshold = 3;

    // One slot always stays behind the read pointer to hold the front word
    localparam int usable_entries = fifo_entries - 1;
    localparam int af_level = usable_entries - af_threshold;

    // Header fields are nibbles, and the payload length is one of them
    localparam int len_bits = 4;
    localparam int hdr_len_nib = 2;

    // Body of a FIFO word
    // In the hdr view nibble 3 is the source tag, nibble 2 the payload length
    // and nibbles 1 and 0 the sequence number
    typedef union packed {
        logic [3:0][len_bits-1:0] hdr;
        logic [word_bits-1:0]     data;
    } fifo_body_u;

    // Bit word_bits marks a header, the lower bits carry the body
    typedef logic [word_bits:0] fifo_word_t;

    function automatic logic [addr_bits:0] bin2gray(input logic [addr_bits:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    function automatic logic [addr_bits:0] gray2bin(input logic [addr_bits:0] gray);
        logic [addr_bits:0] bin;
        bin[addr_bits] = gray[addr_bits];
        // Each binary bit is the XOR of all Gray bits at and above it
        for (int i = addr_bits - 1; i >= 0; i--)
        begin
            bin[i] = bin[i + 1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage
